// File: common/alu_pkg.sv
// ALU package: opcode enum, EFLAGS layout and the shared flag helpers
package alu_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------

	// Operand, result and EFLAGS width
	localparam int DATA_W = 32;

	// ----------------------------------------
	// Opcodes
	// ----------------------------------------

	// Decode numbering, three bits
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_OR  = 3'd1,
		OP_NOT = 3'd2,
		OP_DAA = 3'd3,
		OP_AND = 3'd4,
		OP_CLD = 3'd5,
		OP_CMP = 3'd6,
		OP_STD = 3'd7
	} alu_op_e;

	// ----------------------------------------
	// EFLAGS bit positions
	// ----------------------------------------

	localparam int FLAG_CF = 0;
	localparam int FLAG_PF = 2;
	localparam int FLAG_AF = 4;
	localparam int FLAG_ZF = 6;
	localparam int FLAG_SF = 7;
	localparam int FLAG_DF = 10;
	localparam int FLAG_OF = 11;

	// Six status flags, DF stays outside
	localparam logic [DATA_W-1:0] STATUS_MASK =
		(DATA_W'(1) << FLAG_CF) |
		(DATA_W'(1) << FLAG_PF) |
		(DATA_W'(1) << FLAG_AF) |
		(DATA_W'(1) << FLAG_ZF) |
		(DATA_W'(1) << FLAG_SF) |
		(DATA_W'(1) << FLAG_OF);

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	// PF rule: set on an even count of ones in the low byte
	function automatic logic parity_even(input logic [7:0] byte_in);
		return ~(^byte_in);
	endfunction

	// Ops that update the destination register
	function automatic logic op_writes_result(input alu_op_e op);
		case (op)
			OP_ADD, OP_OR, OP_NOT, OP_DAA, OP_AND: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

// File: common/alu_res_if.sv
// ALU result interface: one computed operation passed from ALU to writeback
`timescale 1ns/1ns

interface alu_res_if;

	// High for every cycle that carries an operation
	logic valid;
	// Opcode of the carried operation
	alu_pkg::alu_op_e op;
	// Computed value, meaningful only for writing ops
	logic [alu_pkg::DATA_W-1:0] result;
	// Status flags in their EFLAGS positions
	logic [alu_pkg::DATA_W-1:0] flags_new;

	// ALU side
	modport src (
		output valid,
		output op,
		output result,
		output flags_new
	);

	// Writeback side, no ready back
	modport dst (
		input valid,
		input op,
		input result,
		input flags_new
	);

endinterface

// File: alu/alu_daa.sv
// ALU DAA: two-digit BCD decimal adjust of one byte with per-digit carries
`timescale 1ns/1ns

module alu_daa (
	input  logic [7:0] digits_in,
	output logic [7:0] digits_out,
	output logic [1:0] carry_out
);

	// ----------------------------------------
	// Low digit
	// ----------------------------------------

	logic [3:0] lo_in;
	logic       lo_carry;
	logic [4:0] lo_adj;

	assign lo_in = digits_in[3:0];

	// Above 9 needs the +6 correction
	assign lo_carry = (lo_in > 4'd9);

	// Extra bit drops out when truncated to a digit
	assign lo_adj = lo_carry ? ({1'b0, lo_in} + 5'd6) : {1'b0, lo_in};

	// ----------------------------------------
	// High digit
	// ----------------------------------------

	logic [4:0] hi_sum;
	logic       hi_carry;
	logic [4:0] hi_adj;

	// Carry ripples from the low digit first
	assign hi_sum = {1'b0, digits_in[7:4]} + {4'd0, lo_carry};

	// Sum can reach 16, still above 9
	assign hi_carry = (hi_sum > 5'd9);

	assign hi_adj = hi_carry ? (hi_sum + 5'd6) : hi_sum;

	// ----------------------------------------
	// Outputs
	// ----------------------------------------

	// Four bits per digit
	assign digits_out = {hi_adj[3:0], lo_adj[3:0]};

	// Bit 0 low digit, bit 1 high digit
	assign carry_out = {hi_carry, lo_carry};

endmodule

// File: alu/alu32.sv
// ALU32: operand stage and combinational compute of result and status flags
`timescale 1ns/1ns

module alu32 (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       issue,
	input  logic [2:0]                 op,
	input  logic [alu_pkg::DATA_W-1:0] a,
	input  logic [alu_pkg::DATA_W-1:0] b,
	alu_res_if.src                     res
);

	// ----------------------------------------
	// Operand registers
	// ----------------------------------------

	logic                       valid_q;
	alu_pkg::alu_op_e           op_q;
	logic [alu_pkg::DATA_W-1:0] a_q;
	logic [alu_pkg::DATA_W-1:0] b_q;

	// Valid lasts exactly one cycle per issue
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue;
		end
	end

	// Payload only loads on issue
	always_ff @(posedge clk) begin
		if (issue) begin
			op_q <= alu_pkg::alu_op_e'(op);
			a_q  <= a;
			b_q  <= b;
		end
	end

	// ----------------------------------------
	// Datapath
	// ----------------------------------------

	// One extra bit holds carry or borrow
	logic [alu_pkg::DATA_W:0] sum;
	logic [alu_pkg::DATA_W:0] diff;
	logic [7:0]               daa_byte;
	logic [1:0]               daa_carry;

	assign sum  = {1'b0, a_q} + {1'b0, b_q};
	assign diff = {1'b0, a_q} - {1'b0, b_q};

	// Decimal adjust works on the low byte only
	alu_daa u_alu_daa (
		.digits_in  (a_q[7:0]),
		.digits_out (daa_byte),
		.carry_out  (daa_carry)
	);

	// ----------------------------------------
	// Result and flag select
	// ----------------------------------------

	logic [alu_pkg::DATA_W-1:0] res_c;
	logic [alu_pkg::DATA_W-1:0] flags_c;
	logic cf;
	logic af;
	logic of;
	logic flags_on;

	always_comb begin
		res_c    = '0;
		cf       = 1'b0;
		af       = 1'b0;
		of       = 1'b0;
		flags_on = 1'b1;
		case (op_q)
			alu_pkg::OP_ADD: begin
				res_c = sum[alu_pkg::DATA_W-1:0];
				cf    = sum[alu_pkg::DATA_W];
				// Carry into bit 4
				af    = a_q[4] ^ b_q[4] ^ sum[4];
				// Same operand signs with the result sign flipped
				of    = (a_q[31] == b_q[31]) && (sum[31] != a_q[31]);
			end
			alu_pkg::OP_CMP: begin
				res_c = diff[alu_pkg::DATA_W-1:0];
				// Borrow rather than the result sign
				cf    = diff[alu_pkg::DATA_W];
				af    = a_q[4] ^ b_q[4] ^ diff[4];
				// Operand signs differ and the result takes b's sign
				of    = (a_q[31] != b_q[31]) && (diff[31] != a_q[31]);
			end
			alu_pkg::OP_OR:  res_c = a_q | b_q;
			alu_pkg::OP_AND: res_c = a_q & b_q;
			alu_pkg::OP_DAA: begin
				// Upper 24 bits stay zero
				res_c = {{(alu_pkg::DATA_W-8){1'b0}}, daa_byte};
				cf    = |daa_carry;
				af    = |daa_carry;
			end
			// NOT writes a result and no flags
			alu_pkg::OP_NOT: begin
				res_c    = ~a_q;
				flags_on = 1'b0;
			end
			// DF ops carry no payload
			alu_pkg::OP_CLD, alu_pkg::OP_STD: flags_on = 1'b0;
		endcase
	end

	// Assemble into EFLAGS positions
	always_comb begin
		flags_c = '0;
		if (flags_on) begin
			flags_c[alu_pkg::FLAG_CF] = cf;
			flags_c[alu_pkg::FLAG_AF] = af;
			flags_c[alu_pkg::FLAG_OF] = of;
			// Top result bit, always clear for DAA
			flags_c[alu_pkg::FLAG_SF] = res_c[alu_pkg::DATA_W-1];
			flags_c[alu_pkg::FLAG_ZF] = (res_c == '0);
			flags_c[alu_pkg::FLAG_PF] = alu_pkg::parity_even(res_c[7:0]);
		end
	end

	// Drive the writeback side
	assign res.valid     = valid_q;
	assign res.op        = op_q;
	assign res.result    = res_c;
	assign res.flags_new = flags_c;

endmodule

// File: logic/alu_writeback.sv
// ALU writeback: result register and architectural EFLAGS update per opcode
`timescale 1ns/1ns

module alu_writeback (
	input  logic                       clk,
	input  logic                       reset,
	alu_res_if.dst                     res,
	output logic [alu_pkg::DATA_W-1:0] result,
	output logic                       result_we,
	output logic [alu_pkg::DATA_W-1:0] eflags
);

	// ----------------------------------------
	// Decode
	// ----------------------------------------

	logic                       we_next;
	logic [alu_pkg::DATA_W-1:0] status_merge;

	// Write only for valid, result-producing ops
	assign we_next = res.valid && alu_pkg::op_writes_result(res.op);

	// Swap status bits in, keep DF and the zero bits
	assign status_merge = (eflags & ~alu_pkg::STATUS_MASK) |
		(res.flags_new & alu_pkg::STATUS_MASK);

	// ----------------------------------------
	// Result register
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			result_we <= 1'b0;
			result    <= '0;
		end else begin
			// Strobe for one cycle per write
			result_we <= we_next;
			if (we_next) begin
				result <= res.result;
			end
		end
	end

	// ----------------------------------------
	// EFLAGS
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			eflags <= '0;
		end else if (res.valid) begin
			case (res.op)
				alu_pkg::OP_CLD: eflags[alu_pkg::FLAG_DF] <= 1'b0;
				alu_pkg::OP_STD: eflags[alu_pkg::FLAG_DF] <= 1'b1;
				// NOT holds every flag
				alu_pkg::OP_NOT: eflags <= eflags;
				default:         eflags <= status_merge;
			endcase
		end
	end

endmodule

// File: logic/alu_exec.sv
// ALU execute slice top: operand stage and writeback joined by the result interface
`timescale 1ns/1ns

module alu_exec (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       issue,
	input  logic [2:0]                 op,
	input  logic [alu_pkg::DATA_W-1:0] a,
	input  logic [alu_pkg::DATA_W-1:0] b,
	output logic [alu_pkg::DATA_W-1:0] result,
	output logic                       result_we,
	output logic [alu_pkg::DATA_W-1:0] eflags
);

	// ----------------------------------------
	// Stage link
	// ----------------------------------------

	// One operation per cycle, no back-pressure
	alu_res_if u_alu_res_if ();

	// ----------------------------------------
	// Operand stage
	// ----------------------------------------

	// Samples on issue, computes in the following cycle
	alu32 u_alu32 (
		.clk   (clk),
		.reset (reset),
		.issue (issue),
		.op    (op),
		.a     (a),
		.b     (b),
		.res   (u_alu_res_if.src)
	);

	// ----------------------------------------
	// Writeback stage
	// ----------------------------------------

	// Registers the payload one edge later
	alu_writeback u_alu_writeback (
		.clk       (clk),
		.reset     (reset),
		.res       (u_alu_res_if.dst),
		.result    (result),
		.result_we (result_we),
		.eflags    (eflags)
	);

endmodule

// File: verif/alu_ref_model.svh
// ALU reference model: expected result, write enable and next EFLAGS from the opcode rules
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// True for an even number of ones in a byte
function automatic logic even_ones(input logic [7:0] x);
	int n;
	n = 0;
	for (int i = 0; i < 8; i++) begin
		if (x[i]) n++;
	end
	return (n % 2) == 0;
endfunction

// Only the five data ops update the destination
function automatic logic writes_dest(input alu_pkg::alu_op_e o);
	case (o)
		alu_pkg::OP_ADD, alu_pkg::OP_OR, alu_pkg::OP_NOT: return 1'b1;
		alu_pkg::OP_DAA, alu_pkg::OP_AND: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// Two-digit BCD adjust done on the whole byte, carry ripples through v
function automatic void bcd_adjust(input logic [7:0] in_byte, output logic [7:0] out_byte,
		output logic carry);
	logic [8:0] v;
	logic       c_lo;
	logic       c_hi;
	v    = {1'b0, in_byte};
	c_lo = (in_byte[3:0] > 4'd9);
	if (c_lo) v = v + 9'h006;
	// High digit already holds the low carry
	c_hi = (v[8:4] > 5'd9);
	if (c_hi) v = v + 9'h060;
	out_byte = v[7:0];
	carry    = c_lo | c_hi;
endfunction

// Result and new status flags for one op
function automatic void compute_op(input alu_pkg::alu_op_e o, input logic [31:0] a_v,
		input logic [31:0] b_v, output logic [31:0] res, output logic [31:0] fl);
	logic [32:0] wide;
	logic [32:0] swide;
	logic [4:0]  nib;
	logic [7:0]  adj;
	logic        dc;
	res = 32'd0;
	fl  = 32'd0;
	case (o)
		alu_pkg::OP_ADD: begin
			wide  = {1'b0, a_v} + {1'b0, b_v};
			swide = {a_v[31], a_v} + {b_v[31], b_v};
			nib   = {1'b0, a_v[3:0]} + {1'b0, b_v[3:0]};
			res   = wide[31:0];
			fl[alu_pkg::FLAG_CF] = wide[32];
			fl[alu_pkg::FLAG_AF] = nib[4];
			// Sign-extended sum disagrees in its top two bits
			fl[alu_pkg::FLAG_OF] = swide[32] ^ swide[31];
		end
		alu_pkg::OP_CMP: begin
			swide = {a_v[31], a_v} - {b_v[31], b_v};
			res   = a_v - b_v;
			// Unsigned borrow
			fl[alu_pkg::FLAG_CF] = (a_v < b_v);
			fl[alu_pkg::FLAG_AF] = (a_v[3:0] < b_v[3:0]);
			fl[alu_pkg::FLAG_OF] = swide[32] ^ swide[31];
		end
		alu_pkg::OP_OR:  res = a_v | b_v;
		alu_pkg::OP_AND: res = a_v & b_v;
		alu_pkg::OP_DAA: begin
			bcd_adjust(a_v[7:0], adj, dc);
			res = {24'd0, adj};
			fl[alu_pkg::FLAG_CF] = dc;
			fl[alu_pkg::FLAG_AF] = dc;
		end
		alu_pkg::OP_NOT: res = ~a_v;
		default: res = 32'd0;
	endcase
	// SF, ZF, PF from the result; DAA upper bits are zero so SF stays 0
	fl[alu_pkg::FLAG_SF] = res[31];
	fl[alu_pkg::FLAG_ZF] = (res == 32'd0);
	fl[alu_pkg::FLAG_PF] = even_ones(res[7:0]);
endfunction

// Architectural EFLAGS after one op
function automatic logic [31:0] next_eflags(input alu_pkg::alu_op_e o, input logic [31:0] fl,
		input logic [31:0] prev);
	logic [31:0] nxt;
	nxt = prev;
	case (o)
		alu_pkg::OP_CLD: nxt[alu_pkg::FLAG_DF] = 1'b0;
		alu_pkg::OP_STD: nxt[alu_pkg::FLAG_DF] = 1'b1;
		alu_pkg::OP_NOT: nxt = prev;
		default: nxt = (prev & ~alu_pkg::STATUS_MASK) | (fl & alu_pkg::STATUS_MASK);
	endcase
	return nxt;
endfunction

`endif

// File: verif/tb_alu_exec.sv
// Testbench for the ALU execute slice: directed and random ops against a pipelined scoreboard
`timescale 1ns/1ns

module tb_alu_exec;

	// ----------------------------------------
	// Run length
	// ----------------------------------------

	localparam int N_DIRECT = 6;
	localparam int N_ARITH  = 300;
	localparam int N_LOGIC  = 60;
	localparam int N_DAA    = 256;
	localparam int N_DF     = 12;
	localparam int N_PIPE   = 200;
	localparam int N_GAP    = 20;
	localparam int N_ISSUED = N_DIRECT + N_ARITH + N_LOGIC + N_DAA + N_DF + N_PIPE + N_GAP;
	// Reset and every issue plus slack for idle slots and drain
	localparam int TIMEOUT_CYCLES = 16 + N_ISSUED + 200;

	logic        clk;
	logic        reset;
	logic        issue;
	logic [2:0]  op;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] result;
	logic        result_we;
	logic [31:0] eflags;

	// One scoreboard slot per cycle, issue or idle
	logic        q_we[$];
	logic [31:0] q_result[$];
	logic [31:0] q_eflags[$];
	string       q_name[$];
	logic        chk_on;
	logic        exp_we;
	logic [31:0] exp_result;
	logic [31:0] exp_eflags;
	string       exp_name;
	string       cur_test;
	logic [31:0] model_eflags;
	int          err_count;
	int          cycle_count;

	`include "alu_ref_model.svh"

	alu_exec alu_exec_inst (
		.clk       (clk),
		.reset     (reset),
		.issue     (issue),
		.op        (op),
		.a         (a),
		.b         (b),
		.result    (result),
		.result_we (result_we),
		.eflags    (eflags)
	);

	// 8 ns period
	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ----------------------------------------
	// Stimulus tasks
	// ----------------------------------------

	task automatic report_mismatch(input string test, input string what,
			input logic [31:0] expv, input logic [31:0] actv);
		err_count++;
		$display("FAILED %s %s expected %08h actual %08h", test, what, expv, actv);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at first mismatch");
	endtask

	// One cycle of input with its expectation queued for the output slot
	task automatic drive_cycle(input logic do_issue, input alu_pkg::alu_op_e o,
			input logic [31:0] va, input logic [31:0] vb);
		logic [31:0] res_e;
		logic [31:0] fl_e;
		@(posedge clk);
		#1;
		issue = do_issue;
		op    = o;
		a     = va;
		b     = vb;
		if (do_issue) begin
			compute_op(o, va, vb, res_e, fl_e);
			model_eflags = next_eflags(o, fl_e, model_eflags);
			q_we.push_back(writes_dest(o));
			q_result.push_back(res_e);
		end else begin
			q_we.push_back(1'b0);
			q_result.push_back(32'd0);
		end
		q_eflags.push_back(model_eflags);
		q_name.push_back(cur_test);
		// Slot from two calls back is checked at the next edge
		if (q_we.size() > 2) begin
			chk_on     = 1'b1;
			exp_we     = q_we.pop_front();
			exp_result = q_result.pop_front();
			exp_eflags = q_eflags.pop_front();
			exp_name   = q_name.pop_front();
		end
	endtask

	task automatic issue_op(input alu_pkg::alu_op_e o, input logic [31:0] va,
			input logic [31:0] vb);
		drive_cycle(1'b1, o, va, vb);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle(1'b0, alu_pkg::OP_ADD, 32'd0, 32'd0);
	endtask

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// Idle, CMP, CLD and STD slots keep the strobe low
	chk_we: assert property (@(posedge clk) disable iff (reset)
		(!chk_on || result_we == exp_we))
		else report_mismatch(exp_name, "result_we", {31'd0, exp_we}, {31'd0, $sampled(result_we)});

	chk_result: assert property (@(posedge clk) disable iff (reset)
		(!chk_on || !exp_we || result == exp_result))
		else report_mismatch(exp_name, "result", exp_result, $sampled(result));

	// Whole register so DF and the zero bits count too
	chk_eflags: assert property (@(posedge clk) disable iff (reset)
		(!chk_on || eflags == exp_eflags))
		else report_mismatch(exp_name, "eflags", exp_eflags, $sampled(eflags));

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial begin
		logic [31:0]       r;
		logic [31:0]       opnd_a;
		alu_pkg::alu_op_e  o;
		void'($urandom(32'h16783049));
		reset        = 1'b1;
		issue        = 1'b0;
		op           = 3'd0;
		a            = 32'd0;
		b            = 32'd0;
		chk_on       = 1'b0;
		exp_we       = 1'b0;
		exp_result   = 32'd0;
		exp_eflags   = 32'd0;
		exp_name     = "reset";
		cur_test     = "reset";
		model_eflags = 32'd0;
		err_count    = 0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		// Quiet outputs and cleared EFLAGS
		idle_cycles(4);

		cur_test = "add_cmp_directed";
		issue_op(alu_pkg::OP_ADD, 32'h7fffffff, 32'h00000001);
		issue_op(alu_pkg::OP_ADD, 32'hffffffff, 32'h00000001);
		issue_op(alu_pkg::OP_ADD, 32'h0000000f, 32'h00000001);
		issue_op(alu_pkg::OP_CMP, 32'h12345678, 32'h12345678);
		issue_op(alu_pkg::OP_CMP, 32'h00000005, 32'h00000009);
		issue_op(alu_pkg::OP_CMP, 32'h80000000, 32'h00000001);

		cur_test = "add_cmp_random";
		for (int i = 0; i < N_ARITH; i++) begin
			r = $urandom();
			o = r[0] ? alu_pkg::OP_CMP : alu_pkg::OP_ADD;
			opnd_a = $urandom();
			// Some equal pairs so CMP reaches ZF
			if (r[2:1] == 2'd0) issue_op(o, opnd_a, opnd_a);
			else issue_op(o, opnd_a, $urandom());
		end

		cur_test = "logic";
		for (int i = 0; i < N_LOGIC; i++) begin
			if (i % 3 == 0) o = alu_pkg::OP_OR;
			else if (i % 3 == 1) o = alu_pkg::OP_AND;
			else o = alu_pkg::OP_NOT;
			issue_op(o, $urandom(), $urandom());
		end

		// Every low byte with random upper bits
		cur_test = "daa";
		for (int i = 0; i < N_DAA; i++) begin
			r = $urandom();
			issue_op(alu_pkg::OP_DAA, {r[31:8], 8'(i)}, $urandom());
		end

		cur_test = "df_control";
		for (int i = 0; i < N_DF; i++) begin
			if (i % 3 == 0) o = (i % 2 == 0) ? alu_pkg::OP_STD : alu_pkg::OP_CLD;
			else o = alu_pkg::OP_ADD;
			issue_op(o, $urandom(), $urandom());
		end

		// Back to back with two ops in flight
		cur_test = "pipeline";
		for (int i = 0; i < N_PIPE; i++) begin
			o = alu_pkg::alu_op_e'(3'($urandom_range(0, 7)));
			issue_op(o, $urandom(), $urandom());
		end

		cur_test = "pipeline_gaps";
		for (int i = 0; i < N_GAP; i++) begin
			o = alu_pkg::alu_op_e'(3'($urandom_range(0, 7)));
			issue_op(o, $urandom(), $urandom());
			idle_cycles($urandom_range(1, 3));
		end

		// Drain the last slots through the checks
		idle_cycles(3);
		@(posedge clk);
		#1;
		if (err_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Cycle limit
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "cycle limit reached");
	end

endmodule

// File: alu_exec.f
+incdir+verif
common/alu_pkg.sv
common/alu_res_if.sv
alu/alu_daa.sv
alu/alu32.sv
logic/alu_writeback.sv
logic/alu_exec.sv
verif/tb_alu_exec.sv

// File: Makefile
# Verilator build and run for the ALU execute slice

VERILATOR ?= verilator
TOP       ?= tb_alu_exec
RTL_TOP   ?= alu_exec
LOG       ?= sim.log
FLIST     ?= alu_exec.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert

RTL_FILES = common/alu_pkg.sv \
	common/alu_res_if.sv \
	alu/alu_daa.sv \
	alu/alu32.sv \
	logic/alu_writeback.sv \
	logic/alu_exec.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
